/* src/ip_mux_consts.svh */
/*
 * Constants for the IP frame multiplexer:
 *   port count and port index width
 *   payload data width
 *   IP header field widths
 */

`ifndef IP_MUX_CONSTS_SVH
`define IP_MUX_CONSTS_SVH

// input ports and the width of an index into them
`define IP_MUX_PORTS 4
`define IP_MUX_SEL_W 2

// payload stream byte width
`define IP_PAYLOAD_W 8

// header fields that survive the mux
`define IP_ADDR_W  32
`define IP_LEN_W   16
`define IP_PROTO_W 8

`endif

/* src/ip_mux_pkg.sv */
/*
 * Shared types for the IP frame multiplexer:
 *   port index and per-port mask vectors
 *   payload byte and IP header field types
 *   selector state encoding
 */

`include "ip_mux_consts.svh"

package ip_mux_pkg;

    // port addressing
    typedef logic [`IP_MUX_SEL_W-1:0] port_sel_t;
    typedef logic [`IP_MUX_PORTS-1:0] port_mask_t;

    // payload stream
    typedef logic [`IP_PAYLOAD_W-1:0] payload_t;

    // header fields
    typedef logic [`IP_ADDR_W-1:0]  ip_addr_t;
    typedef logic [`IP_LEN_W-1:0]   ip_len_t;
    typedef logic [`IP_PROTO_W-1:0] ip_proto_t;

    // whether a frame is currently locked to a port
    typedef enum logic [0:0] {
        SEL_IDLE,
        SEL_FRAME
    } sel_state_e;

endpackage

/* src/ip_payload_if.sv */
/*
 * Payload beat link between the frame selector and the skid buffer,
 * early-ready flavour: src drives data, last and valid, snk answers
 * with ready_early one cycle ahead of the transfer
 */

`timescale 1ns/1ps

interface ip_payload_if
    import ip_mux_pkg::*;
();

    payload_t data;
    logic     last;
    logic     valid;
    // room for one more beat at the next edge, no matter what arrives
    logic     ready_early;

    modport src (output data, output last, output valid, input ready_early);
    modport snk (input data, input last, input valid, output ready_early);

endinterface

/* src/ip_frame_select.sv */
/*
 * Frame selector for the IP multiplexer:
 *   frame lock FSM, latches select at the start of a frame
 *   registered header outputs and one-cycle header ready pulse
 *   registered per-port payload ready driven from the early ready
 *   payload multiplexer onto the beat interface
 */

`timescale 1ns/1ps

`include "ip_mux_consts.svh"

module ip_frame_select
    import ip_mux_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 enable,
    input  port_sel_t                            select,

    // per-port header inputs
    input  port_mask_t                           s_hdr_valid,
    output port_mask_t                           s_hdr_ready,
    input  ip_len_t   [`IP_MUX_PORTS-1:0]        s_ip_length,
    input  ip_proto_t [`IP_MUX_PORTS-1:0]        s_ip_protocol,
    input  ip_addr_t  [`IP_MUX_PORTS-1:0]        s_ip_source_ip,
    input  ip_addr_t  [`IP_MUX_PORTS-1:0]        s_ip_dest_ip,

    // per-port payload inputs
    input  payload_t  [`IP_MUX_PORTS-1:0]        s_payload_data,
    input  port_mask_t                           s_payload_valid,
    input  port_mask_t                           s_payload_last,
    output port_mask_t                           s_payload_ready,

    // selected header output
    output logic                                 m_hdr_valid,
    input  logic                                 m_hdr_ready,
    output ip_len_t                              m_ip_length,
    output ip_proto_t                            m_ip_protocol,
    output ip_addr_t                             m_ip_source_ip,
    output ip_addr_t                             m_ip_dest_ip,

    // selected payload toward the skid buffer
    ip_payload_if.src                            beat
);

    sel_state_e state, state_next;
    port_sel_t  sel_reg, sel_next;
    port_mask_t pay_ready_next;

    logic       frame_start;
    logic       frame_end;
    logic       beat_accept;

    // locked port's payload signals
    payload_t   cur_data;
    logic       cur_valid;
    logic       cur_last;
    logic       cur_ready;

    assign cur_data  = s_payload_data[sel_reg];
    assign cur_valid = s_payload_valid[sel_reg];
    assign cur_last  = s_payload_last[sel_reg];
    assign cur_ready = s_payload_ready[sel_reg];

    // a new frame only locks once the previous header has been taken
    assign frame_start = (state == SEL_IDLE) && enable && !m_hdr_valid &&
                         s_hdr_valid[select];

    assign beat_accept = cur_valid && cur_ready && (state == SEL_FRAME);
    assign frame_end   = beat_accept && cur_last;

    // skid buffer never refuses, so valid is the accepted beat itself
    assign beat.data  = cur_data;
    assign beat.last  = cur_last;
    assign beat.valid = beat_accept;

    always_comb begin
        state_next = state;
        sel_next   = sel_reg;

        case (state)
            SEL_IDLE: begin
                if (frame_start) begin
                    state_next = SEL_FRAME;
                    sel_next   = select;
                end
            end
            SEL_FRAME: begin
                if (frame_end) begin
                    state_next = SEL_IDLE;
                end
            end
            default: begin
                state_next = SEL_IDLE;
            end
        endcase

        // only the locked port sees ready, and only while the frame lasts
        pay_ready_next = '0;
        if (beat.ready_early && (state_next == SEL_FRAME)) begin
            pay_ready_next[sel_next] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= SEL_IDLE;
            sel_reg         <= '0;
            s_hdr_ready     <= '0;
            s_payload_ready <= '0;
            m_hdr_valid     <= 1'b0;
        end else begin
            state           <= state_next;
            sel_reg         <= sel_next;
            s_payload_ready <= pay_ready_next;

            // header ready is a single-cycle pulse for the locked port
            s_hdr_ready <= '0;
            if (frame_start) begin
                s_hdr_ready <= port_mask_t'(1) << select;
            end

            if (frame_start) begin
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
        end
    end

    // header fields, captured at the lock edge
    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_ip_length    <= s_ip_length[select];
            m_ip_protocol  <= s_ip_protocol[select];
            m_ip_source_ip <= s_ip_source_ip[select];
            m_ip_dest_ip   <= s_ip_dest_ip[select];
        end
    end

endmodule

/* src/ip_payload_skid.sv */
/*
 * Two-entry output register for payload beats:
 *   output register and temporary register, each with a valid bit
 *   early ready toward the frame selector
 */

`timescale 1ns/1ps

module ip_payload_skid
    import ip_mux_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    ip_payload_if.snk  beat,

    output payload_t   m_payload_data,
    output logic       m_payload_last,
    output logic       m_payload_valid,
    input  logic       m_payload_ready
);

    payload_t out_data;
    logic     out_last;
    logic     out_valid;

    payload_t temp_data;
    logic     temp_last;
    logic     temp_valid;

    // datapath steering
    logic     store_in_to_out;
    logic     store_in_to_temp;
    logic     store_temp_to_out;

    assign m_payload_data  = out_data;
    assign m_payload_last  = out_last;
    assign m_payload_valid = out_valid;

    // room next cycle if the output drains, or the temp slot stays empty
    // (temp empty and no incoming beat can land in it this cycle)
    assign beat.ready_early = m_payload_ready ||
                              (!temp_valid && (!out_valid || !beat.valid));

    always_comb begin
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (beat.valid) begin
            if (m_payload_ready || !out_valid) begin
                store_in_to_out = 1'b1;
            end else begin
                store_in_to_temp = 1'b1;
            end
        end else if (m_payload_ready) begin
            // output drains, refill it from temp (possibly empty)
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            if (store_in_to_out) begin
                out_valid <= 1'b1;
            end else if (store_temp_to_out) begin
                out_valid  <= temp_valid;
                temp_valid <= 1'b0;
            end

            if (store_in_to_temp) begin
                temp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_data <= beat.data;
            out_last <= beat.last;
        end else if (store_temp_to_out) begin
            out_data <= temp_data;
            out_last <= temp_last;
        end

        if (store_in_to_temp) begin
            temp_data <= beat.data;
            temp_last <= beat.last;
        end
    end

endmodule

/* src/ip_mux.sv */
/*
 * IP frame multiplexer top level:
 *   four header and payload input ports, one registered output
 *   frame selector feeding a two-entry payload skid buffer
 */

`timescale 1ns/1ps

`include "ip_mux_consts.svh"

module ip_mux
    import ip_mux_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,

    // header inputs
    input  port_mask_t                           s_hdr_valid,
    output port_mask_t                           s_hdr_ready,
    input  ip_len_t   [`IP_MUX_PORTS-1:0]        s_ip_length,
    input  ip_proto_t [`IP_MUX_PORTS-1:0]        s_ip_protocol,
    input  ip_addr_t  [`IP_MUX_PORTS-1:0]        s_ip_source_ip,
    input  ip_addr_t  [`IP_MUX_PORTS-1:0]        s_ip_dest_ip,

    // payload inputs
    input  payload_t  [`IP_MUX_PORTS-1:0]        s_payload_data,
    input  port_mask_t                           s_payload_valid,
    input  port_mask_t                           s_payload_last,
    output port_mask_t                           s_payload_ready,

    // header output
    output logic                                 m_hdr_valid,
    input  logic                                 m_hdr_ready,
    output ip_len_t                              m_ip_length,
    output ip_proto_t                            m_ip_protocol,
    output ip_addr_t                             m_ip_source_ip,
    output ip_addr_t                             m_ip_dest_ip,

    // payload output
    output payload_t                             m_payload_data,
    output logic                                 m_payload_last,
    output logic                                 m_payload_valid,
    input  logic                                 m_payload_ready,

    // control
    input  logic                                 enable,
    input  port_sel_t                            select
);

    ip_payload_if beat_if ();

    ip_frame_select sel0 (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .select          (select),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_ip_length     (s_ip_length),
        .s_ip_protocol   (s_ip_protocol),
        .s_ip_source_ip  (s_ip_source_ip),
        .s_ip_dest_ip    (s_ip_dest_ip),
        .s_payload_data  (s_payload_data),
        .s_payload_valid (s_payload_valid),
        .s_payload_last  (s_payload_last),
        .s_payload_ready (s_payload_ready),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_ip_length     (m_ip_length),
        .m_ip_protocol   (m_ip_protocol),
        .m_ip_source_ip  (m_ip_source_ip),
        .m_ip_dest_ip    (m_ip_dest_ip),
        .beat            (beat_if.src)
    );

    // fully registered payload output
    ip_payload_skid skid0 (
        .clk             (clk),
        .rst             (rst),
        .beat            (beat_if.snk),
        .m_payload_data  (m_payload_data),
        .m_payload_last  (m_payload_last),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready)
    );

endmodule

/* testbench/tb_ip_mux.sv */
/*
 * Testbench for the IP frame multiplexer:
 *   clock, reset and per-port frame sources
 *   random output ready from a seeded generator
 *   scoreboard queues with assertion checks on headers and payload
 *   cycle-count timeout and closing report
 */

`timescale 1ns/1ps

`include "ip_mux_consts.svh"

module tb_ip_mux
    import ip_mux_pkg::*;
();

    // the tests need well under half of this
    localparam int MAX_CYCLES = 4000;

    typedef struct packed {
        port_sel_t  port;
        logic [7:0] frame;
        logic [7:0] len;
    } frame_rec_t;

    logic                              clk;
    logic                              rst;
    logic                              enable;
    port_sel_t                         select;
    port_mask_t                        s_hdr_valid;
    port_mask_t                        s_hdr_ready;
    ip_len_t   [`IP_MUX_PORTS-1:0]     s_ip_length;
    ip_proto_t [`IP_MUX_PORTS-1:0]     s_ip_protocol;
    ip_addr_t  [`IP_MUX_PORTS-1:0]     s_ip_source_ip;
    ip_addr_t  [`IP_MUX_PORTS-1:0]     s_ip_dest_ip;
    payload_t  [`IP_MUX_PORTS-1:0]     s_payload_data;
    port_mask_t                        s_payload_valid;
    port_mask_t                        s_payload_last;
    port_mask_t                        s_payload_ready;
    logic                              m_hdr_valid;
    logic                              m_hdr_ready;
    ip_len_t                           m_ip_length;
    ip_proto_t                         m_ip_protocol;
    ip_addr_t                          m_ip_source_ip;
    ip_addr_t                          m_ip_dest_ip;
    payload_t                          m_payload_data;
    logic                              m_payload_last;
    logic                              m_payload_valid;
    logic                              m_payload_ready;

    int         seed;
    int         cycles;
    int         errors;
    int         passed;
    int         failed;
    int         err_start;
    int         stall_lvl;
    logic       hdr_hold;
    int         frame_no [`IP_MUX_PORTS];
    int         pend_frame [`IP_MUX_PORTS];
    int         pend_len [`IP_MUX_PORTS];
    frame_rec_t hdr_q [$];
    frame_rec_t pay_q [$];
    frame_rec_t lock_rec;
    frame_rec_t out_rec;
    int         out_idx;
    logic       frame_active;
    port_sel_t  locked;
    logic       prev_en;
    port_sel_t  prev_sel;

    ip_mux dut0 (.*);

    always #4 clk = ~clk;

    // expected frame contents, from port index and frame number
    function automatic ip_len_t total_length(input int len);
        return ip_len_t'(20 + len);
    endfunction

    function automatic ip_proto_t proto_of(input int p, input int f);
        return ip_proto_t'(16 * p + f + 1);
    endfunction

    function automatic ip_addr_t src_addr(input int p, input int f);
        return ip_addr_t'(32'h0a00_0000 + p * 256 + f);
    endfunction

    function automatic ip_addr_t dst_addr(input int p, input int f);
        return ip_addr_t'(32'hc0a8_0000 + (p + 1) * 256 + f);
    endfunction

    function automatic payload_t payload_byte(input int p, input int i);
        return payload_t'(p * 64 + i);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else begin
            errors++;
            $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    // presents one header and its payload on port p, from posedge + 1 ns
    task automatic send_frame(input int p, input int len);
        int f;
        int i;
        logic took;
        f = frame_no[p];
        frame_no[p] = f + 1;
        pend_frame[p] = f;
        pend_len[p] = len;
        s_ip_length[p] = total_length(len);
        s_ip_protocol[p] = proto_of(p, f);
        s_ip_source_ip[p] = src_addr(p, f);
        s_ip_dest_ip[p] = dst_addr(p, f);
        s_hdr_valid[p] = 1'b1;
        // header stays up until the port sees its ready pulse
        do begin
            @(negedge clk);
            took = s_hdr_ready[p];
            @(posedge clk);
            #1;
        end while (!took);
        s_hdr_valid[p] = 1'b0;
        for (i = 0; i < len; i++) begin
            if (($random(seed) & 7) == 0) begin
                @(posedge clk);
                #1;
            end
            s_payload_data[p] = payload_byte(p, i);
            s_payload_valid[p] = 1'b1;
            s_payload_last[p] = (i == len - 1);
            do begin
                @(negedge clk);
                took = s_payload_ready[p];
                @(posedge clk);
                #1;
            end while (!took);
            s_payload_valid[p] = 1'b0;
            s_payload_last[p] = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (hdr_q.size() != 0 || pay_q.size() != 0 || frame_active) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        wait_drain();
        if (errors == err_start) begin
            passed++;
            $display("%-16s done, no errors", name);
        end else begin
            failed++;
            $display("%-16s done, %0d errors", name, errors - err_start);
        end
        err_start = errors;
    endtask

    // output ready toggles randomly, stall_lvl of 4 slots stall
    always @(posedge clk) begin
        #1;
        m_payload_ready = ($random(seed) & 3) >= stall_lvl;
        m_hdr_ready = !hdr_hold && (($random(seed) & 1) != 0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // scoreboard, sampled mid-cycle where all signals are settled
    always @(negedge clk) begin
        if (!rst) begin
            // a lock shows up as a one-cycle header ready pulse
            if (s_hdr_ready != '0) begin
                assert (s_hdr_ready == (port_mask_t'(1) << prev_sel) && s_hdr_valid[prev_sel])
                else note_error("s_hdr_ready pulsed for a port that was not selected and valid");
                assert (prev_en && !frame_active && hdr_q.size() == 0)
                else note_error("frame locked while disabled, busy or with a header waiting");
                lock_rec.port = prev_sel;
                lock_rec.frame = pend_frame[prev_sel];
                lock_rec.len = pend_len[prev_sel];
                hdr_q.push_back(lock_rec);
                pay_q.push_back(lock_rec);
                locked = prev_sel;
                frame_active = 1'b1;
            end
            check_val("m_hdr_valid", hdr_q.size() != 0, m_hdr_valid);
            assert ((s_payload_ready & (s_payload_ready - 1'b1)) == '0 &&
                    (s_payload_ready == '0 ||
                     (frame_active && s_payload_ready == (port_mask_t'(1) << locked))))
            else note_error("s_payload_ready given to a port that holds no locked frame");
            if (frame_active && s_payload_valid[locked] && s_payload_ready[locked] &&
                s_payload_last[locked]) begin
                frame_active = 1'b0;
            end
            if (m_hdr_valid && m_hdr_ready && hdr_q.size() != 0) begin
                out_rec = hdr_q.pop_front();
                check_val("m_ip_length", total_length(out_rec.len), m_ip_length);
                check_val("m_ip_protocol", proto_of(out_rec.port, out_rec.frame), m_ip_protocol);
                check_val("m_ip_source_ip", src_addr(out_rec.port, out_rec.frame), m_ip_source_ip);
                check_val("m_ip_dest_ip", dst_addr(out_rec.port, out_rec.frame), m_ip_dest_ip);
            end
            if (m_payload_valid && m_payload_ready) begin
                if (pay_q.size() == 0) begin
                    note_error("payload beat delivered with no frame pending");
                end else begin
                    out_rec = pay_q[0];
                    check_val("m_payload_data", payload_byte(out_rec.port, out_idx),
                              m_payload_data);
                    check_val("m_payload_last", out_idx == out_rec.len - 1, m_payload_last);
                    out_idx++;
                    if (out_idx == out_rec.len) begin
                        void'(pay_q.pop_front());
                        out_idx = 0;
                    end
                end
            end
        end
        prev_en = enable;
        prev_sel = select;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        enable = 1'b0;
        select = '0;
        s_hdr_valid = '0;
        s_ip_length = '0;
        s_ip_protocol = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_payload_data = '0;
        s_payload_valid = '0;
        s_payload_last = '0;
        m_hdr_ready = 1'b0;
        m_payload_ready = 1'b0;
        seed = 8;
        cycles = 0;
        errors = 0;
        passed = 0;
        failed = 0;
        err_start = 0;
        stall_lvl = 1;
        hdr_hold = 1'b0;
        out_idx = 0;
        frame_active = 1'b0;
        locked = '0;
        prev_en = 1'b0;
        prev_sel = '0;
        for (int p = 0; p < `IP_MUX_PORTS; p++) begin
            frame_no[p] = 0;
            pend_frame[p] = 0;
            pend_len[p] = 0;
        end

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (s_hdr_ready == '0 && s_payload_ready == '0 && !m_hdr_valid && !m_payload_valid)
        else note_error("outputs not idle after reset");
        finish_test("reset");

        // one frame from every port in turn
        @(posedge clk);
        #1;
        enable = 1'b1;
        for (int p = 0; p < `IP_MUX_PORTS; p++) begin
            select = port_sel_t'(p);
            send_frame(p, 8 + p);
        end
        finish_test("each_port");

        // long frames under heavy output stalls
        stall_lvl = 3;
        @(posedge clk);
        #1;
        for (int r = 0; r < 2; r++) begin
            for (int p = 0; p < `IP_MUX_PORTS; p++) begin
                select = port_sel_t'(p);
                send_frame(p, 40);
            end
        end
        finish_test("backpressure");

        // select moves to port 2 while port 1 is mid-frame
        stall_lvl = 1;
        @(posedge clk);
        #1;
        select = 2'd1;
        fork
            send_frame(1, 16);
            begin
                while (!(frame_active && locked == 2'd1)) begin
                    @(negedge clk);
                end
                repeat (3) @(posedge clk);
                #1;
                select = 2'd2;
            end
            begin
                repeat (2) @(posedge clk);
                #1;
                send_frame(2, 12);
            end
        join
        finish_test("select_change");

        // a pending header waits for enable
        @(posedge clk);
        #1;
        enable = 1'b0;
        select = 2'd3;
        fork
            send_frame(3, 10);
            begin
                repeat (20) @(negedge clk);
                assert (hdr_q.size() == 0 && !m_hdr_valid && !frame_active)
                else note_error("frame locked while enable was low");
                @(posedge clk);
                #1;
                enable = 1'b1;
            end
        join
        finish_test("enable_low");

        // an unread header holds off the next lock
        hdr_hold = 1'b1;
        @(posedge clk);
        #1;
        select = 2'd0;
        send_frame(0, 6);
        select = 2'd1;
        fork
            send_frame(1, 6);
            begin
                repeat (15) @(negedge clk);
                assert (hdr_q.size() == 1 && !frame_active)
                else note_error("second frame locked before the first header was taken");
                hdr_hold = 1'b0;
            end
        join
        finish_test("header_block");

        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/ip_mux_pkg.sv
src/ip_payload_if.sv
src/ip_frame_select.sv
src/ip_payload_skid.sv
src/ip_mux.sv
testbench/tb_ip_mux.sv

/* Bender.yml */
package:
  name: ip_mux

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ip_mux_pkg.sv
      - src/ip_payload_if.sv
      - src/ip_frame_select.sv
      - src/ip_payload_skid.sv
      - src/ip_mux.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_ip_mux.sv
